/* verilog/rv64m_pkg.sv */
package rv64m_pkg;

	localparam int xlen = 64;
	localparam int word_w = 32; // the W ops work on the low half

	// funct3 of the M group with opcode OP / OP-32
	localparam logic [2:0] funct3_mul    = 3'd0;
	localparam logic [2:0] funct3_mulh   = 3'd1;
	localparam logic [2:0] funct3_mulhsu = 3'd2;
	localparam logic [2:0] funct3_mulhu  = 3'd3;

	// which part of the 128-bit product goes back to rd
	typedef enum logic [1:0] {
		sel_low  = 2'd0, // bits 63:0
		sel_high = 2'd1, // bits 127:64
		sel_word = 2'd2  // bits 31:0, sign extended
	} res_sel_e;

endpackage

/* verilog/booth_pkg.sv */
package booth_pkg;

	localparam int acc_w = 130;       // partial product and shifted multiplicand
	localparam int mplier_w = 66;     // 64 bits plus two guard bits
	localparam int booth_digits = 33; // mplier_w / 2
	localparam int cnt_w = 6;

	typedef enum logic [2:0] {
		bop_zero = 3'd0,
		bop_pos1 = 3'd1,
		bop_pos2 = 3'd2,
		bop_neg2 = 3'd3,
		bop_neg1 = 3'd4
	} booth_op_e;

	// window is {b[2i+1], b[2i], b[2i-1]}
	function automatic booth_op_e recode(input logic [2:0] win);
		case (win)
		3'b001, 3'b010: recode = bop_pos1;
		3'b011:         recode = bop_pos2;
		3'b100:         recode = bop_neg2;
		3'b101, 3'b110: recode = bop_neg1;
		default:        recode = bop_zero; // 000 and 111
		endcase
	endfunction

endpackage

/* verilog/mul_core_if.sv */
`timescale 1ns/10ps

interface mul_core_if;

	logic [booth_pkg::acc_w-1:0]    mcand;  // extended src1
	logic [booth_pkg::mplier_w-1:0] mplier; // extended src2
	rv64m_pkg::res_sel_e            res_sel;
	logic                           go;
	logic [booth_pkg::acc_w-1:0]    product;
	logic                           fin;

	modport prep (
		output mcand, mplier, res_sel, go
	);

	modport core (
		input  mcand, mplier, go,
		output product, fin
	);

	modport sel (
		input product, res_sel, fin
	);

endinterface

/* verilog/mul_operand_prep.sv */
`timescale 1ns/10ps

module mul_operand_prep (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  logic [2:0]                 funct3,
	input  logic                       is_word,
	input  logic [rv64m_pkg::xlen-1:0] src1,
	input  logic [rv64m_pkg::xlen-1:0] src2,
	input  logic                       busy,
	mul_core_if.prep                   req
);

	logic                             s1_signed;
	logic                             s2_signed;
	rv64m_pkg::res_sel_e              sel_d;
	logic [booth_pkg::acc_w-1:0]      ext1;
	logic [booth_pkg::mplier_w-1:0]   ext2;
	logic                             take;

	always_comb begin
		s1_signed = 1'b1;
		s2_signed = 1'b1;
		sel_d = rv64m_pkg::sel_low;
		if (is_word) begin
			sel_d = rv64m_pkg::sel_word; // only the low bits matter for mulw
		end else begin
			case (funct3)
			rv64m_pkg::funct3_mulh: begin
				sel_d = rv64m_pkg::sel_high;
			end
			rv64m_pkg::funct3_mulhsu: begin
				s2_signed = 1'b0;
				sel_d = rv64m_pkg::sel_high;
			end
			rv64m_pkg::funct3_mulhu: begin
				s1_signed = 1'b0;
				s2_signed = 1'b0;
				sel_d = rv64m_pkg::sel_high;
			end
			default: ; // mul
			endcase
		end
	end

	assign ext1 = {{(booth_pkg::acc_w-rv64m_pkg::xlen){s1_signed & src1[rv64m_pkg::xlen-1]}}, src1};
	assign ext2 = {{(booth_pkg::mplier_w-rv64m_pkg::xlen){s2_signed & src2[rv64m_pkg::xlen-1]}},
		src2};

	assign take = start & ~busy; // start while busy is dropped

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req.go <= 1'b0;
		end else begin
			req.go <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			req.mcand <= ext1;
			req.mplier <= ext2;
			req.res_sel <= sel_d;
		end
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
		else $error("mul start while busy");

endmodule

/* verilog/booth_radix4_core.sv */
`timescale 1ns/10ps

module booth_radix4_core (
	input  logic     clk,
	input  logic     rst_n,
	mul_core_if.core req,
	output logic     busy
);

	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_load  = 2'd1, // first digit
		st_shift = 2'd2,
		st_last  = 2'd3
	} state_e;

	state_e                         state;
	logic [booth_pkg::cnt_w-1:0]    cnt;
	logic [booth_pkg::acc_w-1:0]    acc;
	logic [booth_pkg::acc_w-1:0]    mcand_r;
	logic [booth_pkg::acc_w-1:0]    term;
	logic [booth_pkg::mplier_w-1:0] mplier_r;
	logic                           prev_bit; // bit 2i-1 of the multiplier
	logic                           run;
	booth_pkg::booth_op_e           op;

	assign run = (state != st_idle);
	assign op = booth_pkg::recode({mplier_r[1:0], prev_bit});

	always_comb begin
		case (op)
		booth_pkg::bop_pos1: term = mcand_r;
		booth_pkg::bop_pos2: term = mcand_r << 1;
		booth_pkg::bop_neg2: term = ~(mcand_r << 1) + 1'b1;
		booth_pkg::bop_neg1: term = ~mcand_r + 1'b1;
		default:             term = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cnt <= '0;
			req.fin <= 1'b0;
		end else begin
			req.fin <= 1'b0;
			case (state)
			st_idle: begin
				if (req.go) begin
					state <= st_load;
					cnt <= '0;
				end
			end
			st_load: begin
				cnt <= cnt + 1'b1;
				state <= st_shift;
			end
			st_shift: begin
				cnt <= cnt + 1'b1;
				// one digit left after this one
				if (cnt == booth_pkg::cnt_w'(booth_pkg::booth_digits - 2))
					state <= st_last;
			end
			st_last: begin
				cnt <= cnt + 1'b1;
				req.fin <= 1'b1;
				state <= st_idle;
			end
			default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!run) begin
			if (req.go) begin
				mcand_r <= req.mcand;
				mplier_r <= req.mplier;
				prev_bit <= 1'b0;
				acc <= '0;
			end
		end else begin
			acc <= acc + term;
			mcand_r <= mcand_r << 2; // weight 4 per digit
			mplier_r <= mplier_r >> 2;
			prev_bit <= mplier_r[1];
		end
	end

	assign req.product = acc;

	// go and fin cover the edges of the run
	assign busy = req.go | run | req.fin;

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		cnt <= booth_pkg::cnt_w'(booth_pkg::booth_digits))
		else $error("booth digit counter overrun");

	a_fin_pulse: assert property (@(posedge clk) disable iff (!rst_n) req.fin |=> !req.fin)
		else $error("fin wider than one cycle");

endmodule

/* verilog/mul_result_sel.sv */
`timescale 1ns/10ps

module mul_result_sel (
	input  logic                       clk,
	input  logic                       rst_n,
	mul_core_if.sel                    req,
	output logic                       done,
	output logic [rv64m_pkg::xlen-1:0] result
);

	localparam int xl = rv64m_pkg::xlen;
	localparam int wl = rv64m_pkg::word_w;

	logic [xl-1:0] pick;

	always_comb begin
		case (req.res_sel)
		rv64m_pkg::sel_high: pick = req.product[2*xl-1:xl];
		rv64m_pkg::sel_word: pick = {{(xl-wl){req.product[wl-1]}}, req.product[wl-1:0]};
		default:             pick = req.product[xl-1:0];
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
			result <= '0;
		end else begin
			done <= req.fin;
			if (req.fin)
				result <= pick; // held until next done
		end
	end

endmodule

/* verilog/mul_unit.sv */
`timescale 1ns/10ps

module mul_unit (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  logic [2:0]                 funct3,
	input  logic                       is_word,
	input  logic [rv64m_pkg::xlen-1:0] src1,
	input  logic [rv64m_pkg::xlen-1:0] src2,
	output logic                       busy,
	output logic                       done,
	output logic [rv64m_pkg::xlen-1:0] result
);

	mul_core_if u_if ();

	mul_operand_prep u_prep (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.funct3  (funct3),
		.is_word (is_word),
		.src1    (src1),
		.src2    (src2),
		.busy    (busy),
		.req     (u_if.prep)
	);

	booth_radix4_core u_core (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (u_if.core),
		.busy  (busy)
	);

	mul_result_sel u_sel (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (u_if.sel),
		.done   (done),
		.result (result)
	);

endmodule

/* dv/tb_mul_unit.sv */
`timescale 1ns/10ps

module tb_mul_unit;

	localparam int done_latency = 36;
	localparam int timeout_cycles = 100;
	localparam int random_pairs = 200;

	logic        clk;
	logic        rst_n;
	logic        start;
	logic [2:0]  funct3;
	logic        is_word;
	logic [63:0] src1;
	logic [63:0] src2;
	logic        busy;
	logic        done;
	logic [63:0] result;

	int    errors;
	int    err_at_start;
	int    tests_run;
	int    tests_failed;
	string cur_name;

	// index 1 of the op table is the word form
	logic [2:0] op_f3 [5] = '{rv64m_pkg::funct3_mul, rv64m_pkg::funct3_mul,
		rv64m_pkg::funct3_mulh, rv64m_pkg::funct3_mulhsu, rv64m_pkg::funct3_mulhu};
	logic       op_w [5] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
	string      op_nm [5] = '{"mul", "mulw", "mulh", "mulhsu", "mulhu"};

	logic [63:0] corners [6] = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff,
		64'h8000_0000_0000_0000, 64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555};

	mul_unit UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.funct3  (funct3),
		.is_word (is_word),
		.src1    (src1),
		.src2    (src2),
		.busy    (busy),
		.done    (done),
		.result  (result)
	);

	always #10 clk = ~clk;

	// 128-bit product of the extended sources, then the RV64M selection
	function automatic logic [63:0] expect_result(input logic [2:0] f3, input logic w,
		input logic [63:0] a, input logic [63:0] b);
		logic         a_signed;
		logic         b_signed;
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] p;
		a_signed = 1'b1;
		b_signed = 1'b1;
		if (!w && f3 == rv64m_pkg::funct3_mulhu) begin
			a_signed = 1'b0;
			b_signed = 1'b0;
		end
		if (!w && f3 == rv64m_pkg::funct3_mulhsu)
			b_signed = 1'b0;
		ea = {{64{a_signed & a[63]}}, a};
		eb = {{64{b_signed & b[63]}}, b};
		p = ea * eb;
		if (w)
			return {{32{p[31]}}, p[31:0]};
		else if (f3 == rv64m_pkg::funct3_mul)
			return p[63:0];
		else
			return p[127:64];
	endfunction

	task automatic begin_test(input string name);
		cur_name = name;
		err_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == err_at_start) begin
			$display("PASS %s", cur_name);
		end else begin
			tests_failed++;
			$display("FAIL %s", cur_name);
		end
	endtask

	// issue one request on the next rising edge, wait for done, check result
	task automatic run_op(input string name, input int op, input logic [63:0] a,
		input logic [63:0] b, output int lat, output bit busy_ok);
		logic [63:0] exp;
		int          n;
		bit          got;
		exp = expect_result(op_f3[op], op_w[op], a, b);
		n = 0;
		got = 0;
		busy_ok = 1;
		@(posedge clk);
		start <= 1'b1;
		funct3 <= op_f3[op];
		is_word <= op_w[op];
		src1 <= a;
		src2 <= b;
		while (!got && n < timeout_cycles) begin
			@(negedge clk);
			n++;
			if (done) begin
				got = 1;
				if (busy)
					busy_ok = 0; // should drop with done
			end else if (busy != (n > 1)) begin
				busy_ok = 0;
			end
			if (!got) begin
				@(posedge clk);
				start <= 1'b0;
			end
		end
		lat = n - 1; // negedge n lies in cycle n-1 after the start edge
		if (!got) begin
			$display("%s: done did not arrive within %0d cycles", name, timeout_cycles);
			errors++;
		end else if (result !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, result);
			errors++;
		end
	endtask

	task automatic reset_values();
		begin_test("reset");
		@(negedge clk);
		if (busy !== 1'b0) begin
			$display("ERR reset busy expected 0 actual %b", busy);
			errors++;
		end
		if (done !== 1'b0) begin
			$display("ERR reset done expected 0 actual %b", done);
			errors++;
		end
		if (result !== 64'h0) begin
			$display("ERR reset result expected %h actual %h", 64'h0, result);
			errors++;
		end
		end_test();
	endtask

	task automatic corner_products();
		int lat;
		bit busy_ok;
		begin_test("corners");
		for (int op = 0; op < 5; op++) begin
			for (int i = 0; i < 6; i++) begin
				for (int j = 0; j < 6; j++)
					run_op($sformatf("corners %s", op_nm[op]), op, corners[i], corners[j],
						lat, busy_ok);
			end
		end
		end_test();
	endtask

	task automatic random_products();
		int lat;
		bit busy_ok;
		begin_test("random");
		for (int op = 0; op < 5; op++) begin
			for (int k = 0; k < random_pairs; k++)
				run_op($sformatf("random %s", op_nm[op]), op, {$urandom, $urandom},
					{$urandom, $urandom}, lat, busy_ok);
		end
		end_test();
	endtask

	task automatic done_timing();
		int lat;
		bit busy_ok;
		begin_test("timing");
		for (int op = 0; op < 5; op++) begin
			run_op($sformatf("timing %s", op_nm[op]), op, {$urandom, $urandom},
				{$urandom, $urandom}, lat, busy_ok);
			if (lat != done_latency) begin
				$display("ERR timing %s expected %0d actual %0d", op_nm[op], done_latency, lat);
				errors++;
			end
			if (!busy_ok) begin
				$display("timing %s: busy was not high from the cycle after start until done",
					op_nm[op]);
				errors++;
			end
		end
		end_test();
	endtask

	// each run_op starts on the edge right after the previous done
	task automatic back_to_back();
		int lat;
		bit busy_ok;
		int op;
		begin_test("back_to_back");
		for (int k = 0; k < 12; k++) begin
			op = $urandom_range(4, 0);
			run_op($sformatf("back_to_back %0d %s", k, op_nm[op]), op, {$urandom, $urandom},
				{$urandom, $urandom}, lat, busy_ok);
		end
		end_test();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		funct3 = 3'd0;
		is_word = 1'b0;
		src1 = '0;
		src2 = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'h9ac1));
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		reset_values();
		corner_products();
		random_products();
		done_timing();
		back_to_back();

		$display("tests %0d failed %0d errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* flist.f */
verilog/rv64m_pkg.sv
verilog/booth_pkg.sv
verilog/mul_core_if.sv
verilog/mul_operand_prep.sv
verilog/booth_radix4_core.sv
verilog/mul_result_sel.sv
verilog/mul_unit.sv
dv/tb_mul_unit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mul_unit
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
